/* sramMem_macros.svh */
`ifndef SRAM_MEM_MACROS_SVH
`define SRAM_MEM_MACROS_SVH

// external SRAM geometry
`define SRAM_DW 16
`define SRAM_AW 18

// processor side, data and address alike
`define CPU_DW 32

`define MEM_BASE_RST 32'd1024 // start of data memory in processor space

// wait states per half-word phase, 0 up to this
`define MAX_WAIT 3

`endif

/* memReqPkg.sv */
`default_nettype none

`include "sramMem_macros.svh"

package memReqPkg;

    // one processor request, enables held as levels
    typedef struct packed {
        logic               wrEn;
        logic               rdEn;
        logic [`CPU_DW-1:0] addr;
        logic [`CPU_DW-1:0] wData;
    } memReqT;

    localparam int WORD_IDX_W = `SRAM_AW - 1;             // one bit left for low/high half
    localparam int UPPER_W    = `CPU_DW - WORD_IDX_W - 2;

    // offset split into 32-bit word index and byte lane
    typedef struct packed {
        logic [UPPER_W-1:0]    upper;   // beyond the SRAM
        logic [WORD_IDX_W-1:0] wordIdx;
        logic [1:0]            byteOff; // ignored, word accesses only
    } addrFieldsT;

    typedef union packed {
        logic [`CPU_DW-1:0] raw;   // for the base subtraction
        addrFieldsT         parts;
    } addrViewU;

endpackage

`default_nettype wire

/* sramBusPkg.sv */
`default_nettype none

`include "sramMem_macros.svh"

package sramBusPkg;

    localparam int WAIT_W = $clog2(`MAX_WAIT + 1);

    // pins driven by the controller
    typedef struct packed {
        logic [`SRAM_AW-1:0] addr;
        logic                weN;   // active low
        logic [`SRAM_DW-1:0] dqOut;
        logic                dqOe;  // controller owns the data bus
    } sramCmdT;

    typedef struct packed {
        logic [`CPU_DW-1:0] baseAddr;
        logic [WAIT_W-1:0]  waitStates;
    } timingCfgT;

    typedef enum logic {
        CFG_BASE,
        CFG_WAIT
    } cfgSelT;

endpackage

`default_nettype wire

/* sramTimingRegs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sramMem_macros.svh"

module sramTimingRegs (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cfgWr,   // one-cycle strobe
    input  wire sramBusPkg::cfgSelT   cfgSel,
    input  wire logic [`CPU_DW-1:0]   cfgData,
    input  wire logic                 busy,    // controller not idle
    output sramBusPkg::timingCfgT     cfg
);

    import sramBusPkg::*;

    logic [`CPU_DW-1:0] baseReg;
    logic [WAIT_W-1:0]  waitReg;
    logic               wrBase;
    logic               wrWait;

    // decode the strobe into one write enable per register
    assign wrBase = cfgWr && (cfgSel == CFG_BASE);
    assign wrWait = cfgWr && (cfgSel == CFG_WAIT);

    // base address subtracted from every processor address
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            baseReg <= `MEM_BASE_RST;
        end else if (wrBase) begin
            baseReg <= cfgData;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            waitReg <= '0;                      // fastest timing out of reset
        end else if (wrWait) begin
            waitReg <= cfgData[WAIT_W-1:0];     // upper bits dropped
        end
    end

    assign cfg.baseAddr   = baseReg;
    assign cfg.waitStates = waitReg;

    // timing must not move under an access in flight
    cfgWhileIdle : assert property (
        @(posedge clk) disable iff (rst)
        cfgWr |-> !busy
    ) else $error("cfg write while controller busy");

endmodule

`default_nettype wire

/* sramController.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sramMem_macros.svh"

module sramController (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire memReqPkg::memReqT    req,
    input  wire sramBusPkg::timingCfgT cfg,
    input  wire logic [`SRAM_DW-1:0]  dqIn,
    output logic [`CPU_DW-1:0]        rData,
    output logic                      ready,  // low freezes the pipeline
    output logic                      busy,
    output sramBusPkg::sramCmdT       cmd
);

    import memReqPkg::*;
    import sramBusPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOW,
        HIGH,
        DONE
    } stateT;

    stateT               state;
    stateT               nextState;
    logic [WAIT_W-1:0]   waitCnt;   // cycles spent in the current phase
    logic                phaseEnd;
    logic                anyReq;
    addrViewU            offset;
    logic [`SRAM_AW-1:0] lowIdx;
    logic [`SRAM_AW-1:0] highIdx;

    assign anyReq = req.rdEn | req.wrEn;

    // processor address relative to the start of the SRAM window
    assign offset.raw = req.addr - cfg.baseAddr;

    // each 32-bit word takes two consecutive half-words
    assign lowIdx  = {offset.parts.wordIdx, 1'b0};
    assign highIdx = {offset.parts.wordIdx, 1'b1};

    assign phaseEnd = (waitCnt == cfg.waitStates); // last cycle of LOW or HIGH

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (anyReq) begin
                    nextState = LOW;
                end
            end
            LOW: begin
                if (phaseEnd) begin
                    nextState = HIGH;
                end
            end
            HIGH: begin
                if (phaseEnd) begin
                    nextState = DONE;
                end
            end
            DONE: nextState = IDLE; // requester drops its enable here
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // wait counter restarts at every phase boundary
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            waitCnt <= '0;
        end else if ((state == LOW || state == HIGH) && !phaseEnd) begin
            waitCnt <= waitCnt + 1'b1;
        end else begin
            waitCnt <= '0;
        end
    end

    // read halves sampled on the closing cycle of their phase
    always_ff @(posedge clk) begin
        if (req.rdEn && phaseEnd) begin
            if (state == LOW) begin
                rData[`SRAM_DW-1:0] <= dqIn;
            end else if (state == HIGH) begin
                rData[`CPU_DW-1:`SRAM_DW] <= dqIn;
            end
        end
    end

    always_comb begin
        // bus parked outside the two data phases
        cmd.addr  = '0;
        cmd.weN   = 1'b1;
        cmd.dqOut = '0;
        cmd.dqOe  = 1'b0;
        case (state)
            LOW: begin
                cmd.addr  = lowIdx;
                cmd.weN   = ~req.wrEn;
                cmd.dqOut = req.wData[`SRAM_DW-1:0];
                cmd.dqOe  = req.wrEn;
            end
            HIGH: begin
                cmd.addr  = highIdx;
                cmd.weN   = ~req.wrEn;
                cmd.dqOut = req.wData[`CPU_DW-1:`SRAM_DW];
                cmd.dqOe  = req.wrEn;
            end
            default: begin
            end
        endcase
    end

    // high when idle with nothing pending, or for the single DONE cycle
    assign ready = (state == DONE) || (state == IDLE && !anyReq);
    assign busy  = (state != IDLE);

    oneEnable : assert property (
        @(posedge clk) disable iff (rst)
        !(req.rdEn && req.wrEn)
    ) else $error("read and write enable both set");

    // pins follow req combinationally through both phases
    reqHeldInPhase : assert property (
        @(posedge clk) disable iff (rst)
        (state == LOW || state == HIGH) |-> $stable(req)
    ) else $error("request changed during an access");

endmodule

`default_nettype wire

/* sramSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sramMem_macros.svh"

module sramSubsystem (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire memReqPkg::memReqT    req,
    output logic [`CPU_DW-1:0]        rData,
    output logic                      ready,
    input  wire logic                 cfgWr,
    input  wire sramBusPkg::cfgSelT   cfgSel,
    input  wire logic [`CPU_DW-1:0]   cfgData,
    output logic [`SRAM_AW-1:0]       sramAddr,
    output logic                      sramWeN,
    output logic [`SRAM_DW-1:0]       dqOut,
    output logic                      dqOe,
    input  wire logic [`SRAM_DW-1:0]  dqIn,
    output logic                      ubN,
    output logic                      lbN,
    output logic                      ceN,
    output logic                      oeN
);

    import sramBusPkg::*;

    timingCfgT cfg;
    sramCmdT   cmd;
    logic      busy;

    sramTimingRegs regs0 (
        .clk     (clk),
        .rst     (rst),
        .cfgWr   (cfgWr),
        .cfgSel  (cfgSel),
        .cfgData (cfgData),
        .busy    (busy),
        .cfg     (cfg)
    );

    sramController ctrl0 (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .cfg   (cfg),
        .dqIn  (dqIn),
        .rData (rData),
        .ready (ready),
        .busy  (busy),
        .cmd   (cmd)
    );

    // tristate bus split for simulation, drivers resolved outside
    assign sramAddr = cmd.addr;
    assign sramWeN  = cmd.weN;
    assign dqOut    = cmd.dqOut;
    assign dqOe     = cmd.dqOe;

    assign {ubN, lbN, ceN, oeN} = 4'b0000; // both bytes, chip and outputs always on

endmodule

`default_nettype wire

/* sramModel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sramMem_macros.svh"

// behavioral asynchronous 16-bit SRAM, testbench only
module sramModel (
    input  wire logic                clk,
    input  wire logic [`SRAM_AW-1:0] addr,
    input  wire logic                weN,
    input  wire logic                ceN,
    input  wire logic                oeN,
    input  wire logic [`SRAM_DW-1:0] din,
    input  wire logic                dinOe,  // controller drives the data bus
    output logic [`SRAM_DW-1:0]      dout
);

    localparam int DEPTH = 1 << `SRAM_AW;

    logic [`SRAM_DW-1:0] mem [0:DEPTH-1];

    // power-up contents, every address bit takes part
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 16'((i * 40503) ^ (i >> 7));
        end
    end

    // read path has no clock, like the real part
    assign dout = (!ceN && !oeN && weN) ? mem[addr] : '0;

    // write sampled at the edge while the strobe is low
    always @(posedge clk) begin
        if (!ceN && !weN && dinOe) begin
            mem[addr] <= din;
        end
    end

endmodule

`default_nettype wire

/* tb_sramSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sramMem_macros.svh"

module tb_sramSubsystem;

    import memReqPkg::*;
    import sramBusPkg::*;

    localparam int CLK_NS    = 4;
    localparam int WINDOW    = 16;                   // words touched by the random test
    localparam int NUM_OPS   = 2 + WINDOW + 200 + 8 + 2;
    localparam int OP_CYCLES = 2 * (1 + `MAX_WAIT) + 1;
    // slowest timing for every access, plus drive and release cycles and reset
    localparam int LIMIT_NS  = NUM_OPS * OP_CYCLES * CLK_NS + NUM_OPS * 3 * CLK_NS
                               + 100 * CLK_NS;

    logic                clk;
    logic                rst;
    memReqT              req;
    logic [`CPU_DW-1:0]  rData;
    logic                ready;
    logic                cfgWr;
    cfgSelT              cfgSel;
    logic [`CPU_DW-1:0]  cfgData;
    logic [`SRAM_AW-1:0] sramAddr;
    logic                sramWeN;
    logic [`SRAM_DW-1:0] dqOut;
    logic                dqOe;
    logic [`SRAM_DW-1:0] dqIn;
    logic                ubN;
    logic                lbN;
    logic                ceN;
    logic                oeN;

    logic [`SRAM_DW-1:0] shadow [0:(1 << `SRAM_AW)-1]; // last written half-words
    logic [`CPU_DW-1:0]  baseShadow;
    logic [`SRAM_AW-1:0] lowSeen;    // sramAddr in the first LOW cycle
    logic [`SRAM_AW-1:0] highSeen;   // sramAddr in the last HIGH cycle
    int                  errCount;
    int                  checkCount;
    int                  readsChecked;
    int                  testsRun;
    int                  testsPassed;

    sramSubsystem dut0 (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .rData    (rData),
        .ready    (ready),
        .cfgWr    (cfgWr),
        .cfgSel   (cfgSel),
        .cfgData  (cfgData),
        .sramAddr (sramAddr),
        .sramWeN  (sramWeN),
        .dqOut    (dqOut),
        .dqOe     (dqOe),
        .dqIn     (dqIn),
        .ubN      (ubN),
        .lbN      (lbN),
        .ceN      (ceN),
        .oeN      (oeN)
    );

    sramModel sram0 (
        .clk   (clk),
        .addr  (sramAddr),
        .weN   (sramWeN),
        .ceN   (ceN),
        .oeN   (oeN),
        .din   (dqOut),
        .dinOe (dqOe),
        .dout  (dqIn)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // word index from the offset, then the half select as last bit
    function automatic logic [`SRAM_AW-1:0] halfIndex(input logic [`CPU_DW-1:0] base,
                                                      input logic [`CPU_DW-1:0] addr,
                                                      input logic hi);
        logic [`CPU_DW-1:0] off;
        off = addr - base;
        return {off[`SRAM_AW:2], hi};
    endfunction

    function automatic logic [`CPU_DW-1:0] expectedRead(input logic [`CPU_DW-1:0] base,
                                                        input logic [`CPU_DW-1:0] addr);
        return {shadow[halfIndex(base, addr, 1'b1)], shadow[halfIndex(base, addr, 1'b0)]};
    endfunction

    task automatic checkWord(input string name, input logic [`CPU_DW-1:0] got,
                             input logic [`CPU_DW-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input logic [`SRAM_AW-1:0] got,
                             input logic [`SRAM_AW-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkLatency(input string name, input int got, input int exp);
        checkCount++;
        if (got != exp) begin
            errCount++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // one full access, cycles counted from the edge that samples the request
    task automatic runAccess(input logic isWrite, input logic [`CPU_DW-1:0] addr,
                             input logic [`CPU_DW-1:0] data, output int cycles,
                             output logic [`CPU_DW-1:0] rd);
        memReqT r;
        r.wrEn  = isWrite;
        r.rdEn  = !isWrite;
        r.addr  = addr;
        r.wData = data;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles == 1) begin
                lowSeen = sramAddr;
            end
            if (!ready) begin
                highSeen = sramAddr;
            end
        end while (!ready);
        rd = rData;           // value held through DONE
        req <= '0;
        if (isWrite) begin
            shadow[halfIndex(baseShadow, addr, 1'b0)] = data[`SRAM_DW-1:0];
            shadow[halfIndex(baseShadow, addr, 1'b1)] = data[`CPU_DW-1:`SRAM_DW];
        end
    endtask

    task automatic writeConfig(input cfgSelT sel, input logic [`CPU_DW-1:0] data);
        @(posedge clk);
        cfgWr   <= 1'b1;
        cfgSel  <= sel;
        cfgData <= data;
        @(posedge clk);       // register loads here
        cfgWr <= 1'b0;
        if (sel == CFG_BASE) begin
            baseShadow = data;
        end
    endtask

    task automatic finishTest(input int num, input string name, input int errBefore);
        @(negedge clk);       // lets the read monitor settle its last edge
        testsRun++;
        if (errCount == errBefore) begin
            testsPassed++;
            $display("test %0d %s: passed", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, errCount - errBefore);
        end
    endtask

    // every completed read compared against the shadow copy
    always @(posedge clk) begin
        if (!rst && req.rdEn && ready) begin
            readsChecked++;
            checkWord("rData", rData, expectedRead(baseShadow, req.addr));
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout after %0d ns, ready never came", LIMIT_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        int                 cycles;
        int                 errBefore;
        int                 idx;
        logic [`CPU_DW-1:0] addr;
        logic [`CPU_DW-1:0] data;
        logic [`CPU_DW-1:0] rd;
        logic [`CPU_DW-1:0] newBase;

        clk          = 1'b0;
        rst          = 1'b1;
        req          = '0;
        cfgWr        = 1'b0;
        cfgSel       = CFG_BASE;
        cfgData      = '0;
        errCount     = 0;
        checkCount   = 0;
        readsChecked = 0;
        testsRun     = 0;
        testsPassed  = 0;
        baseShadow   = `MEM_BASE_RST;
        void'($urandom(69365));

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        errBefore = errCount;
        @(posedge clk);
        checkLevel("ready", ready, 1'b1);
        checkLevel("sramWeN", sramWeN, 1'b1);
        checkLevel("dqOe", dqOe, 1'b0);
        checkAddr("sramAddr", sramAddr, '0);
        checkLevel("ubN", ubN, 1'b0);
        checkLevel("lbN", lbN, 1'b0);
        checkLevel("ceN", ceN, 1'b0);
        checkLevel("oeN", oeN, 1'b0);
        finishTest(1, "reset state", errBefore);

        errBefore = errCount;
        addr = baseShadow + 32'h20;
        data = 32'hCAFE_1234;
        runAccess(1'b1, addr, data, cycles, rd);
        checkAddr("sramAddr low", lowSeen, halfIndex(baseShadow, addr, 1'b0));
        checkAddr("sramAddr high", highSeen, halfIndex(baseShadow, addr, 1'b1));
        runAccess(1'b0, addr, '0, cycles, rd);
        checkAddr("sramAddr low", lowSeen, halfIndex(baseShadow, addr, 1'b0));
        checkAddr("sramAddr high", highSeen, halfIndex(baseShadow, addr, 1'b1));
        checkWord("rData", rd, data);
        finishTest(2, "write and read back", errBefore);

        errBefore = errCount;
        for (int i = 0; i < WINDOW; i++) begin
            data = $urandom;
            runAccess(1'b1, baseShadow + 32'(i * 4), data, cycles, rd);
        end
        for (int n = 0; n < 200; n++) begin
            idx  = $urandom_range(WINDOW - 1, 0);
            addr = baseShadow + 32'(idx * 4);
            data = $urandom;
            if ($urandom_range(1, 0) == 1) begin
                runAccess(1'b1, addr, data, cycles, rd);
            end else begin
                runAccess(1'b0, addr, '0, cycles, rd);
            end
        end
        finishTest(3, "random reads and writes", errBefore);

        errBefore = errCount;
        for (int w = 0; w <= `MAX_WAIT; w++) begin
            writeConfig(CFG_WAIT, 32'hA5A5_A5A4 | 32'(w));   // junk above the two bits
            addr = baseShadow + 32'h100 + 32'(w * 4);
            data = $urandom;
            runAccess(1'b1, addr, data, cycles, rd);
            checkLatency("write latency", cycles, 2 * (1 + w) + 1);
            runAccess(1'b0, addr, '0, cycles, rd);
            checkLatency("read latency", cycles, 2 * (1 + w) + 1);
            checkWord("rData", rd, data);
        end
        writeConfig(CFG_WAIT, '0);
        finishTest(4, "wait state latency", errBefore);

        errBefore = errCount;
        newBase = 32'h0004_0000;
        writeConfig(CFG_BASE, newBase);
        addr = newBase + 32'h84;
        data = $urandom;
        runAccess(1'b1, addr, data, cycles, rd);
        checkAddr("sramAddr low", lowSeen, halfIndex(newBase, addr, 1'b0));
        checkAddr("sramAddr high", highSeen, halfIndex(newBase, addr, 1'b1));
        runAccess(1'b0, addr, '0, cycles, rd);
        checkAddr("sramAddr low", lowSeen, halfIndex(newBase, addr, 1'b0));
        checkWord("rData", rd, data);
        finishTest(5, "moved base address", errBefore);

        $display("tests passed %0d of %0d, checks %0d, reads compared %0d, errors %0d",
                 testsPassed, testsRun, checkCount, readsChecked, errCount);
        if (errCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sramSubsystem.f */
+incdir+.
memReqPkg.sv
sramBusPkg.sv
sramTimingRegs.sv
sramController.sv
sramSubsystem.sv
sramModel.sv
tb_sramSubsystem.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sramSubsystem \
    -f sramSubsystem.f

simOut="$(./obj_dir/Vtb_sramSubsystem)"
echo "$simOut"

if grep -qx "Everything OK" <<< "$simOut"; then
    exit 0
else
    exit 1
fi
